// ==== partition_optimizer.sv ====
// partition optimizer that finds the cheapest eligible rice parameter.
`timescale 1ns/100ps

module partition_optimizer
    import rice_pkg::*;
(
    input  logic                       iClock,
    input  logic                       rst_n,
    input  logic                       sample_valid,
    input  logic signed [SAMPLE_W-1:0] residual,
    input  logic                       clear,
    output logic                       done,
    output logic [PARAM_W-1:0]         best
);

    logic [SAMPLE_W-1:0]   zz;
    logic [SAMPLE_W-1:0]   max_zz;
    logic [SAMPLE_W-1:0]   max_nxt;
    logic [COST_W-1:0]     cost     [0:MAX_PARAM];
    logic [COST_W-1:0]     cost_nxt [0:MAX_PARAM];
    logic [COST_W-1:0]     best_cost;
    logic [PART_CNT_W-1:0] cnt;
    logic [PART_CNT_W-1:0] cnt_base;
    logic                  last;
    logic [PARAM_W-1:0]    pick;

    assign zz = zigzag(residual);

    // a clear in the same cycle as a sample starts a fresh partition with it.
    assign cnt_base = clear ? '0 : cnt;
    assign last     = sample_valid && (cnt_base == PART_CNT_W'(PART_LEN - 1));

    always_comb begin
        for (int p = 0; p <= MAX_PARAM; p++) begin
            cost_nxt[p] = (clear ? '0 : cost[p]) + COST_W'(zz >> p) + COST_W'(p + 1);
        end
        if (clear || zz > max_zz) begin
            max_nxt = zz;
        end else begin
            max_nxt = max_zz;
        end
    end

    //////////////////////////////////////////////////
    // strict compare keeps the lowest p on a tie.
    //////////////////////////////////////////////////
    always_comb begin
        pick      = PARAM_W'(MAX_PARAM);
        best_cost = '1;
        for (int p = 0; p <= MAX_PARAM; p++) begin
            if ((max_nxt >> p) <= MAX_QUOT && cost_nxt[p] < best_cost) begin
                pick      = PARAM_W'(p);
                best_cost = cost_nxt[p];
            end
        end
    end

    always_ff @(posedge iClock or negedge rst_n) begin
        if (!rst_n) begin
            cnt    <= '0;
            max_zz <= '0;
            done   <= 1'b0;
            best   <= '0;
            for (int p = 0; p <= MAX_PARAM; p++) begin
                cost[p] <= '0;
            end
        end else begin
            done <= last;
            if (last) begin
                best   <= pick;
                cnt    <= '0;
                max_zz <= '0;
                for (int p = 0; p <= MAX_PARAM; p++) begin
                    cost[p] <= '0;
                end
            end else if (sample_valid) begin
                cnt    <= cnt_base + 1'b1;
                max_zz <= max_nxt;
                cost   <= cost_nxt;
            end else if (clear) begin
                cnt    <= '0;
                max_zz <= '0;
                for (int p = 0; p <= MAX_PARAM; p++) begin
                    cost[p] <= '0;
                end
            end
        end
    end

endmodule

// ==== residual_delay.sv ====
// valid-tagged delay line for residuals and their partition and frame marks.
`timescale 1ns/100ps

module residual_delay
    import rice_pkg::*;
(
    input  logic                       iClock,
    input  logic                       rst_n,
    input  logic                       in_valid,
    input  logic signed [SAMPLE_W-1:0] in_residual,
    input  logic                       in_part_start,
    input  logic                       in_frame_end,
    output logic                       out_valid,
    output logic signed [SAMPLE_W-1:0] out_residual,
    output logic                       out_part_start,
    output logic                       out_frame_end
);

    logic [DELAY_LEN-1:0]       v;
    logic [DELAY_LEN-1:0]       ps;
    logic [DELAY_LEN-1:0]       fe;
    logic signed [SAMPLE_W-1:0] res [DELAY_LEN];
    logic                       drain;
    logic                       adv;

    // a frame end in flight keeps the line moving every cycle.
    // otherwise it moves with incoming samples.
    assign drain = |(v[DELAY_LEN-2:0] & fe[DELAY_LEN-2:0]);
    assign adv   = in_valid | drain;

    always_ff @(posedge iClock or negedge rst_n) begin
        if (!rst_n) begin
            v <= '0;
        end else if (adv) begin
            v <= {v[DELAY_LEN-2:0], in_valid};
        end else begin
            v[DELAY_LEN-1] <= 1'b0;
        end
    end

    always_ff @(posedge iClock) begin
        if (adv) begin
            ps     <= {ps[DELAY_LEN-2:0], in_part_start};
            fe     <= {fe[DELAY_LEN-2:0], in_frame_end};
            res[0] <= in_residual;
            for (int i = 1; i < DELAY_LEN; i++) begin
                res[i] <= res[i-1];
            end
        end
    end

    assign out_valid      = v[DELAY_LEN-1];
    assign out_residual   = res[DELAY_LEN-1];
    assign out_part_start = ps[DELAY_LEN-1];
    assign out_frame_end  = fe[DELAY_LEN-1];

endmodule

// ==== rice_bit_packer.sv ====
// bit packer that writes param fields and rice codes to ram as 16-bit words.
`timescale 1ns/100ps

module rice_bit_packer
    import rice_pkg::*;
(
    input  logic              iClock,
    input  logic              rst_n,
    rice_code_if.dst          code,
    input  logic              part_start,
    input  logic              frame_end,
    output logic              ram_we1,
    output logic [ADDR_W-1:0] ram_addr1,
    output logic [WORD_W-1:0] ram_data1,
    output logic              ram_we2,
    output logic [ADDR_W-1:0] ram_addr2,
    output logic [WORD_W-1:0] ram_data2,
    output logic              frame_written
);

    // pending bits sit right-aligned in acc, fill says how many.
    logic [ACC_W-1:0]  acc;
    logic [ACC_W-1:0]  cat;
    logic [ACC_W-1:0]  aligned;
    logic [ACC_W-1:0]  acc_nxt;
    logic [FILL_W-1:0] fill;
    logic [FILL_W-1:0] code_len;
    logic [FILL_W-1:0] add_len;
    logic [FILL_W-1:0] cat_fill;
    logic [FILL_W-1:0] pad_bits;
    logic [FILL_W-1:0] eff_fill;
    logic [FILL_W-1:0] n_words;
    logic [1:0]        emit;
    logic [ADDR_W-1:0] addr;
    logic              flush_pend;
    logic              fe_now;

    //////////////////////////////////////////////////
    // append field and code, then cut words.
    //////////////////////////////////////////////////
    always_comb begin
        code_len = FILL_W'(code.quot) + FILL_W'(code.param) + FILL_W'(1);
        add_len  = code_len + (part_start ? FILL_W'(PARAM_W) : '0);
        cat      = acc;
        cat_fill = fill;
        if (code.valid) begin
            // zeros, stop bit, low bits, with the param field in front.
            cat = (acc << add_len)
                | (ACC_W'(part_start ? code.param : '0) << code_len)
                | ACC_W'(code.low)
                | (ACC_W'(1) << code.param);
            cat_fill = fill + add_len;
        end
        fe_now   = code.valid && frame_end;
        pad_bits = fe_now ? FILL_W'((WORD_W - cat_fill % WORD_W) % WORD_W) : '0;
        eff_fill = cat_fill + pad_bits;
        n_words  = eff_fill / FILL_W'(WORD_W);
        emit     = (n_words > 2) ? 2'd2 : n_words[1:0];
        // oldest bit lands on the msb, stale bits fall off the top.
        aligned  = cat << (FILL_W'(ACC_W) - cat_fill);
        acc_nxt  = cat << pad_bits;
    end

    always_ff @(posedge iClock or negedge rst_n) begin
        if (!rst_n) begin
            fill          <= '0;
            addr          <= '0;
            flush_pend    <= 1'b0;
            frame_written <= 1'b0;
            ram_we1       <= 1'b0;
            ram_we2       <= 1'b0;
        end else begin
            fill          <= eff_fill - FILL_W'(emit * WORD_W);
            addr          <= addr + ADDR_W'(emit);
            ram_we1       <= (emit != 2'd0);
            ram_we2       <= (emit == 2'd2);
            // a padded word left over goes out first in the next cycle.
            flush_pend    <= fe_now && (n_words > 2);
            frame_written <= (fe_now && (n_words <= 2)) || flush_pend;
        end
    end

    always_ff @(posedge iClock) begin
        acc       <= acc_nxt;
        ram_addr1 <= addr;
        ram_addr2 <= addr + 1'b1;
        ram_data1 <= aligned[ACC_W-1 -: WORD_W];
        ram_data2 <= aligned[ACC_W-WORD_W-1 -: WORD_W];
    end

endmodule

// ==== rice_code_if.sv ====
// interface for one coded residual between the encoder and the bit packer.
`timescale 1ns/100ps

interface rice_code_if
    import rice_pkg::*;
();

    logic               valid;
    // number of zeros ahead of the stop bit.
    logic [CODE_W-1:0]  quot;
    logic [CODE_W-1:0]  low;
    logic [PARAM_W-1:0] param;

    modport src (
        output valid,
        output quot,
        output low,
        output param
    );

    modport dst (
        input valid,
        input quot,
        input low,
        input param
    );

endinterface

// ==== rice_compress_stage.sv ====
// top of the rice compress stage with two optimizers, delay line, encoder and packer.
`timescale 1ns/100ps

module rice_compress_stage
    import rice_pkg::*;
(
    input  logic                       iClock,
    input  logic                       rst_n,
    input  logic                       sample_valid,
    input  logic signed [SAMPLE_W-1:0] residual,
    input  logic                       frame_done,
    output logic                       ram_we1,
    output logic [ADDR_W-1:0]          ram_addr1,
    output logic [WORD_W-1:0]          ram_data1,
    output logic                       ram_we2,
    output logic [ADDR_W-1:0]          ram_addr2,
    output logic [WORD_W-1:0]          ram_data2,
    output logic                       frame_written
);

    logic                       sel;
    logic                       steer;
    logic                       a_done;
    logic                       b_done;
    logic [PARAM_W-1:0]         a_best;
    logic [PARAM_W-1:0]         b_best;
    logic [PARAM_W-1:0]         current_param;
    logic [PARAM_W-1:0]         active_param;
    logic [PARAM_W-1:0]         enc_param;
    logic [PART_CNT_W-1:0]      part_cnt;
    logic                       d_valid;
    logic signed [SAMPLE_W-1:0] d_residual;
    logic                       d_part_start;
    logic                       d_frame_end;
    logic                       c_part_start;
    logic                       c_frame_end;

    rice_code_if code_bus ();

    // a sample arriving with done already belongs to the other optimizer.
    assign steer = sel ^ (a_done | b_done);

    partition_optimizer opt_a (
        .iClock       (iClock),
        .rst_n        (rst_n),
        .sample_valid (sample_valid & ~steer),
        .residual     (residual),
        .clear        (b_done),
        .done         (a_done),
        .best         (a_best)
    );

    partition_optimizer opt_b (
        .iClock       (iClock),
        .rst_n        (rst_n),
        .sample_valid (sample_valid & steer),
        .residual     (residual),
        .clear        (a_done),
        .done         (b_done),
        .best         (b_best)
    );

    residual_delay u_delay (
        .iClock         (iClock),
        .rst_n          (rst_n),
        .in_valid       (sample_valid),
        .in_residual    (residual),
        .in_part_start  (part_cnt == '0),
        .in_frame_end   (frame_done),
        .out_valid      (d_valid),
        .out_residual   (d_residual),
        .out_part_start (d_part_start),
        .out_frame_end  (d_frame_end)
    );

    // the new parameter takes over at the partition's first delayed sample.
    assign enc_param = d_part_start ? current_param : active_param;

    rice_encoder u_encoder (
        .iClock   (iClock),
        .rst_n    (rst_n),
        .in_valid (d_valid),
        .residual (d_residual),
        .param    (enc_param),
        .code     (code_bus.src)
    );

    rice_bit_packer u_packer (
        .iClock        (iClock),
        .rst_n         (rst_n),
        .code          (code_bus.dst),
        .part_start    (c_part_start),
        .frame_end     (c_frame_end),
        .ram_we1       (ram_we1),
        .ram_addr1     (ram_addr1),
        .ram_data1     (ram_data1),
        .ram_we2       (ram_we2),
        .ram_addr2     (ram_addr2),
        .ram_data2     (ram_data2),
        .frame_written (frame_written)
    );

    //////////////////////////////////////////////////
    // partition sequencing.
    //////////////////////////////////////////////////
    always_ff @(posedge iClock or negedge rst_n) begin
        if (!rst_n) begin
            sel           <= 1'b0;
            current_param <= '0;
            active_param  <= '0;
            part_cnt      <= '0;
            c_part_start  <= 1'b0;
            c_frame_end   <= 1'b0;
        end else begin
            if (a_done | b_done) begin
                sel           <= ~sel;
                current_param <= a_done ? a_best : b_best;
            end
            if (sample_valid) begin
                if (frame_done || part_cnt == PART_CNT_W'(PART_LEN - 1)) begin
                    part_cnt <= '0;
                end else begin
                    part_cnt <= part_cnt + 1'b1;
                end
            end
            if (d_valid) begin
                active_param <= enc_param;
            end
            // marks ride alongside the encoder register.
            c_part_start <= d_valid & d_part_start;
            c_frame_end  <= d_valid & d_frame_end;
        end
    end

endmodule

// ==== rice_compress_sva.sv ====
// bound assertions on the bit packer ram ports and the code interface.
`timescale 1ns/100ps

module rice_compress_sva
    import rice_pkg::*;
(
    input logic              iClock,
    input logic              rst_n,
    input logic              ram_we1,
    input logic              ram_we2,
    input logic [ADDR_W-1:0] ram_addr1,
    input logic [ADDR_W-1:0] ram_addr2,
    input logic              code_valid,
    input logic [CODE_W-1:0] code_quot
);

    // next free ram address as counted from the writes on both ports.
    logic [ADDR_W-1:0] exp_addr;

    always_ff @(posedge iClock or negedge rst_n) begin
        if (!rst_n) begin
            exp_addr <= '0;
        end else begin
            exp_addr <= exp_addr + ADDR_W'(ram_we1) + ADDR_W'(ram_we2);
        end
    end

    // port 2 only carries the second word of a code that completed two.
    a_we2_needs_we1: assert property (@(posedge iClock) disable iff (!rst_n)
        ram_we2 |-> ram_we1 && $past(code_valid))
        else $error("ram_we2 high without ram_we1 or without a code the cycle before");

    a_addr1_next: assert property (@(posedge iClock) disable iff (!rst_n)
        ram_we1 |-> (ram_addr1 == exp_addr))
        else $error("ram_addr1 does not continue from the previous write");

    a_addr2_next: assert property (@(posedge iClock) disable iff (!rst_n)
        ram_we2 |-> (ram_addr2 == exp_addr + ADDR_W'(1)))
        else $error("ram_addr2 is not ram_addr1 plus one");

    a_quot_bound: assert property (@(posedge iClock) disable iff (!rst_n)
        code_valid |-> (code_quot <= CODE_W'(MAX_QUOT)))
        else $error("code quotient above the eligibility bound");

endmodule

bind rice_bit_packer rice_compress_sva sva_checks (
    .iClock     (iClock),
    .rst_n      (rst_n),
    .ram_we1    (ram_we1),
    .ram_we2    (ram_we2),
    .ram_addr1  (ram_addr1),
    .ram_addr2  (ram_addr2),
    .code_valid (code.valid),
    .code_quot  (code.quot)
);

// ==== rice_encoder.sv ====
// rice encoder that splits one zigzag residual into quotient and low bits.
`timescale 1ns/100ps

module rice_encoder
    import rice_pkg::*;
(
    input  logic                       iClock,
    input  logic                       rst_n,
    input  logic                       in_valid,
    input  logic signed [SAMPLE_W-1:0] residual,
    input  logic [PARAM_W-1:0]         param,
    rice_code_if.src                   code
);

    logic [SAMPLE_W-1:0] zz;
    logic [SAMPLE_W-1:0] low_mask;

    assign zz       = zigzag(residual);
    assign low_mask = (SAMPLE_W'(1) << param) - SAMPLE_W'(1);

    always_ff @(posedge iClock or negedge rst_n) begin
        if (!rst_n) begin
            code.valid <= 1'b0;
        end else begin
            code.valid <= in_valid;
        end
    end

    // code fields only change with a new residual.
    always_ff @(posedge iClock) begin
        if (in_valid) begin
            code.quot  <= CODE_W'(zz >> param);
            code.low   <= CODE_W'(zz & low_mask);
            code.param <= param;
        end
    end

endmodule

// ==== rice_pkg.sv ====
// shared widths, sizes and the zigzag mapping for the rice coding stage.
package rice_pkg;

    //////////////////////////////////////////////////
    // stream geometry.
    //////////////////////////////////////////////////
    localparam int SAMPLE_W   = 16;
    localparam int PART_LEN   = 16;
    localparam int PART_CNT_W = $clog2(PART_LEN);
    localparam int DELAY_LEN  = PART_LEN + 2;

    //////////////////////////////////////////////////
    // rice parameter search.
    //////////////////////////////////////////////////
    localparam int MAX_PARAM = 14;
    localparam int PARAM_W   = 4;
    localparam int MAX_QUOT  = 16;
    localparam int COST_W    = 16;

    // code word fields, quotient and low bits share the payload width.
    localparam int CODE_W = 32;

    //////////////////////////////////////////////////
    // ram side and bit packing.
    //////////////////////////////////////////////////
    localparam int WORD_W = 16;
    localparam int ADDR_W = 16;
    localparam int ACC_W  = (WORD_W - 1) + PARAM_W + CODE_W;
    localparam int FILL_W = $clog2(ACC_W + 1);

    // signed residual to unsigned: 0,-1,1,-2,2 map to 0,1,2,3,4.
    function automatic logic [SAMPLE_W-1:0] zigzag(input logic signed [SAMPLE_W-1:0] r);
        logic [SAMPLE_W-1:0] sign_fill;
        sign_fill = {SAMPLE_W{r[SAMPLE_W-1]}};
        return {r[SAMPLE_W-2:0], 1'b0} ^ sign_fill;
    endfunction

endpackage

// ==== run.sh ====
#!/usr/bin/env bash
# build the rice compress testbench with Verilator, run it and check the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -rf obj_dir "$LOG"

verilator --binary --timing --assert -f tb.f --top-module tb_rice_compress -o sim_rice
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_rice > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
fi

if grep -qx "TEST PASS" "$LOG"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see $LOG"
    exit 1
fi

// ==== tb.f ====
rice_pkg.sv
rice_code_if.sv
partition_optimizer.sv
residual_delay.sv
rice_encoder.sv
rice_bit_packer.sv
rice_compress_stage.sv
rice_compress_sva.sv
tb_rice_compress.sv

// ==== tb_rice_compress.sv ====
// testbench for the rice compress stage with stimulus, reference bitstream and ram checks.
`timescale 1ns/100ps

module tb_rice_compress
    import rice_pkg::*;
();

    logic                       iClock;
    logic                       rst_n;
    logic                       sample_valid;
    logic signed [SAMPLE_W-1:0] residual;
    logic                       frame_done;
    logic                       ram_we1;
    logic [ADDR_W-1:0]          ram_addr1;
    logic [WORD_W-1:0]          ram_data1;
    logic                       ram_we2;
    logic [ADDR_W-1:0]          ram_addr2;
    logic [WORD_W-1:0]          ram_data2;
    logic                       frame_written;

    integer            seed = 32'h34a74baf;
    int                res_q[$];
    int                gap_q[$];
    bit                last_q[$];
    int                frame_first[$];
    int                frame_parts[$];
    logic [WORD_W-1:0] exp_words[$];
    // port flag, address, data.
    logic [32:0]       got_q[$];
    logic [32:0]       ent;
    string             data_name;
    int                n_words;
    int                n_we2;
    int                n_fw;
    int                next_idx;
    int                limit_ns;
    int                n;

    rice_compress_stage DUT (.*);

    always #10 iClock = ~iClock;

    task automatic abort_run();
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input int got, input int exp);
        if (got !== exp) begin
            $display("ERR %s got 0x%0h exp 0x%0h", name, got, exp);
            abort_run();
        end
    endtask

    function automatic int zz_value(input int r);
        return (r < 0) ? (-2 * r - 1) : (2 * r);
    endfunction

    //////////////////////////////////////////////////
    // stimulus frames.
    //////////////////////////////////////////////////
    // kind 0 zeros, 1 random, 2 outliers, 3 gapped copy of frame src.
    task automatic add_frame(input int kind, input int parts, input int src);
        int k;
        int i;
        int lim;
        int pos;
        int r;
        int gap;
        frame_first.push_back(res_q.size());
        frame_parts.push_back(parts);
        for (k = 0; k < parts; k++) begin
            lim = 2 << ($random(seed) & 7);
            pos = $random(seed) & (PART_LEN - 1);
            for (i = 0; i < PART_LEN; i++) begin
                r   = 0;
                gap = 0;
                case (kind)
                    1: r = $random(seed) % lim;
                    2: begin
                        if (k == 0) begin
                            // two long codes, the first completes two words.
                            r = (i == 2 || i == 9) ? -136 : 0;
                        end else if (k == 1) begin
                            r = (i == pos) ? 255 : 0;
                        end else begin
                            r = (i == pos) ? -255 : $random(seed) % 4;
                        end
                    end
                    3: begin
                        r   = res_q[frame_first[src] + k * PART_LEN + i];
                        gap = (k == 0 && i == 0) ? 3 * PART_LEN : ($random(seed) & 3);
                    end
                    default: r = 0;
                endcase
                res_q.push_back(r);
                gap_q.push_back(gap);
                last_q.push_back(k == parts - 1 && i == PART_LEN - 1);
            end
        end
    endtask

    //////////////////////////////////////////////////
    // reference bitstream.
    //////////////////////////////////////////////////
    function automatic void ref_stream();
        int                pos;
        int                f;
        int                k;
        int                i;
        int                p;
        int                b;
        int                zz;
        int                mx;
        int                c;
        int                best_p;
        int                best_c;
        bit                bits_q[$];
        logic [WORD_W-1:0] w;
        pos = 0;
        for (f = 0; f < frame_parts.size(); f++) begin
            for (k = 0; k < frame_parts[f]; k++) begin
                mx = 0;
                for (i = 0; i < PART_LEN; i++) begin
                    if (zz_value(res_q[pos + i]) > mx) mx = zz_value(res_q[pos + i]);
                end
                // lowest cost among parameters whose largest quotient fits.
                best_p = -1;
                best_c = 0;
                for (p = 0; p <= MAX_PARAM; p++) begin
                    c = 0;
                    for (i = 0; i < PART_LEN; i++) begin
                        c += (zz_value(res_q[pos + i]) >> p) + 1 + p;
                    end
                    if ((mx >> p) <= MAX_QUOT && (best_p < 0 || c < best_c)) begin
                        best_p = p;
                        best_c = c;
                    end
                end
                for (b = PARAM_W - 1; b >= 0; b--) bits_q.push_back(best_p[b]);
                for (i = 0; i < PART_LEN; i++) begin
                    zz = zz_value(res_q[pos + i]);
                    repeat (zz >> best_p) bits_q.push_back(1'b0);
                    bits_q.push_back(1'b1);
                    for (b = best_p - 1; b >= 0; b--) bits_q.push_back(zz[b]);
                end
                pos += PART_LEN;
            end
            while (bits_q.size() % WORD_W != 0) bits_q.push_back(1'b0);
        end
        for (i = 0; i < bits_q.size(); i += WORD_W) begin
            w = '0;
            for (b = 0; b < WORD_W; b++) w = {w[WORD_W-2:0], bits_q[i + b]};
            exp_words.push_back(w);
        end
    endfunction

    //////////////////////////////////////////////////
    // ram write monitor and compare.
    //////////////////////////////////////////////////
    always @(negedge iClock) begin
        if (ram_we1) begin
            got_q.push_back({1'b0, ram_addr1, ram_data1});
            n_words++;
        end
        if (ram_we2) begin
            got_q.push_back({1'b1, ram_addr2, ram_data2});
            n_words++;
            n_we2++;
        end
        if (frame_written) n_fw++;
    end

    always @(posedge iClock) begin
        while (got_q.size() != 0) begin
            ent = got_q.pop_front();
            if (next_idx >= exp_words.size()) begin
                $display("a ram write arrived after the whole expected stream");
                abort_run();
            end else begin
                data_name = ent[32] ? "ram_data2" : "ram_data1";
                check_value(ent[32] ? "ram_addr2" : "ram_addr1", 32'(ent[31:16]), next_idx);
                check_value(data_name, 32'(ent[15:0]), 32'(exp_words[next_idx]));
                next_idx++;
            end
        end
    end

    initial begin
        wait (limit_ns != 0);
        #(limit_ns);
        $display("frame_written never arrived for every frame within the time limit");
        abort_run();
    end

    initial begin
        iClock       = 1'b0;
        rst_n        = 1'b0;
        sample_valid = 1'b0;
        residual     = '0;
        frame_done   = 1'b0;
        n_words      = 0;
        n_we2        = 0;
        n_fw         = 0;
        next_idx     = 0;
        limit_ns     = 0;
        add_frame(0, 2, 0);
        add_frame(1, 2, 0);
        add_frame(1, 2, 0);
        add_frame(1, 2, 0);
        add_frame(2, 3, 0);
        add_frame(3, 2, 2);
        add_frame(1, 2, 0);
        ref_stream();
        limit_ns = (res_q.size() + frame_parts.size() * 3 * PART_LEN) * 20 * 4;
        repeat (16) @(negedge iClock);
        rst_n = 1'b1;
        repeat (20) @(negedge iClock);
        check_value("ram writes before data", n_words, 0);
        for (n = 0; n < res_q.size(); n++) begin
            repeat (gap_q[n]) begin
                @(negedge iClock);
                sample_valid = 1'b0;
                frame_done   = 1'b0;
            end
            @(negedge iClock);
            sample_valid = 1'b1;
            residual     = SAMPLE_W'(res_q[n]);
            frame_done   = last_q[n];
        end
        @(negedge iClock);
        sample_valid = 1'b0;
        frame_done   = 1'b0;
        while (n_fw < frame_parts.size()) @(negedge iClock);
        repeat (10) @(negedge iClock);
        check_value("frame_written pulses", n_fw, frame_parts.size());
        check_value("ram_we2 used", 32'(n_we2 != 0), 1);
        check_value("ram words written", n_words, exp_words.size());
        if (got_q.size() == 0 && next_idx == exp_words.size()) begin
            $display("TEST PASS");
            $finish;
        end else begin
            $display("not every expected word was checked at the end of the run");
            abort_run();
        end
    end

endmodule
